// File: bench/camera_pipeline_chk.sv
//====================================================================
// Capture stage checker
// Bound into ccd_capture, watches frame gating and the column index
//====================================================================

module camera_pipeline_chk
  import video_pkg::*;
#(
  parameter int LINE_WIDTH = 1280  // Max raw columns per line
) (
  input logic           ccd_pixel_clk,
  input logic           rst,
  input capture_state_t state,
  input logic           cap_valid,
  input coord_t         cap_x
);

  int unsigned fail_count = 0;  // Failure tally

  // Samples leave only inside a captured frame
  valid_in_active: assert property (
    @(posedge ccd_pixel_clk) disable iff (rst)
    cap_valid |-> state == CAP_ACTIVE
  ) else begin
    $error("cap_valid high outside CAP_ACTIVE");
    fail_count++;
  end

  col_in_range: assert property (
    @(posedge ccd_pixel_clk) disable iff (rst)
    cap_valid |-> cap_x < LINE_WIDTH  // Line buffer index
  ) else begin
    $error("cap_x beyond LINE_WIDTH on a valid sample");
    fail_count++;
  end

  // Reset clears the strobe one edge later
  quiet_in_reset: assert property (
    @(posedge ccd_pixel_clk) rst |=> !cap_valid
  ) else begin
    $error("cap_valid high while rst is asserted");
    fail_count++;
  end

endmodule

bind ccd_capture camera_pipeline_chk #(
  .LINE_WIDTH (LINE_WIDTH)
) chk_i (
  .ccd_pixel_clk (ccd_pixel_clk),
  .rst           (rst),
  .state         (state),
  .cap_valid     (cap_valid),
  .cap_x         (cap_x)
);

// File: bench/camera_pipeline_tb.sv
//====================================================================
// Camera pipeline testbench
// Replays Bayer frames from the trace file and compares every
// frame-buffer write and the captured-frame count with the trace
//====================================================================

module camera_pipeline_tb
  import video_pkg::*;
();

  localparam int LINE_WIDTH      = 8;
  localparam int ROWS            = 4;
  localparam int NUM_FRAMES      = 4;
  localparam int RECORD_LEN      = 3 + ROWS * LINE_WIDTH + 8;  // Header, samples, words
  localparam int TRACE_WORDS     = NUM_FRAMES * RECORD_LEN;
  localparam int WATCHDOG_CYCLES = NUM_FRAMES * 80 + 200;

  logic         ccd_pixel_clk;
  logic         rst;
  raw_pixel_t   pin_data;
  logic         pin_fval;
  logic         pin_lval;
  logic         start;
  pixel_mode_t  mode;
  fb_word_t     fb_word;
  logic         fb_write;
  frame_count_t frame_count;

  logic [15:0] trace_mem [TRACE_WORDS];
  logic [15:0] got_words [$];  // Writes seen since the last frame check

  camera_pipeline_top #(
    .LINE_WIDTH (LINE_WIDTH)
  ) dut_i (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .pin_data      (pin_data),
    .pin_fval      (pin_fval),
    .pin_lval      (pin_lval),
    .start         (start),
    .mode          (mode),
    .fb_word       (fb_word),
    .fb_write      (fb_write),
    .frame_count   (frame_count)
  );

  //====================================================================
  // Helpers
  //====================================================================

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      fail_run($sformatf("mismatch time=%0t %s got=0x%0h expected=0x%0h",
                         $time, name, got, exp));
    end
  endtask

  // One pixel clock, inputs change just after the edge
  task automatic drive_pins(input raw_pixel_t data, input logic fval, input logic lval);
    @(posedge ccd_pixel_clk);
    #1;
    pin_data = data;
    pin_fval = fval;
    pin_lval = lval;
  endtask

  // Code 2 raises start only after the first row
  task automatic send_frame(input int base, input logic [15:0] start_code);
    start = (start_code == 16'd1);
    repeat (2) drive_pins('0, 1'b0, 1'b0);
    repeat (4) drive_pins('0, 1'b1, 1'b0);  // Frame valid leads line valid
    for (int row = 0; row < ROWS; row++) begin
      for (int col = 0; col < LINE_WIDTH; col++) begin
        drive_pins(raw_pixel_t'(trace_mem[base + 3 + row * LINE_WIDTH + col]), 1'b1, 1'b1);
      end
      repeat (4) drive_pins('0, 1'b1, 1'b0);  // Line blanking
      if (row == 0 && start_code == 16'd2) start = 1'b1;
    end
    drive_pins('0, 1'b0, 1'b0);  // Frame valid falls
  endtask

  //====================================================================
  // Clock, output monitor, watchdogs
  //====================================================================

  initial begin
    ccd_pixel_clk = 1'b0;
    forever #4 ccd_pixel_clk = ~ccd_pixel_clk;
  end

  always @(negedge ccd_pixel_clk) begin
    if (fb_write) got_words.push_back(fb_word);  // Mid-cycle, outputs settled
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge ccd_pixel_clk);
    fail_run("timeout, the pipeline did not finish the trace in time");
  end

  initial begin
    wait (dut_i.capture_i.chk_i.fail_count != 0);
    fail_run("a capture stage assertion failed");
  end

  //====================================================================
  // Trace replay
  //====================================================================

  initial begin
    int base;
    int exp_count;
    int captured;
    rst      = 1'b1;
    pin_data = '0;
    pin_fval = 1'b0;
    pin_lval = 1'b0;
    start    = 1'b0;
    mode     = MODE_HUE;
    captured = 0;
    $readmemh("bench/camera_trace.txt", trace_mem);
    assert (!$isunknown(trace_mem[TRACE_WORDS - 1])) else begin
      fail_run("trace file is missing or too short");
    end
    repeat (10) @(posedge ccd_pixel_clk);
    #1;
    rst = 1'b0;
    check_value("frame_count", frame_count, 0);
    for (int f = 0; f < NUM_FRAMES; f++) begin
      base      = f * RECORD_LEN;
      exp_count = int'(trace_mem[base + 2]);
      mode      = pixel_mode_t'(trace_mem[base + 1][0]);  // Held for the whole frame
      send_frame(base, trace_mem[base]);
      while (got_words.size() < exp_count) drive_pins('0, 1'b0, 1'b0);
      repeat (12) drive_pins('0, 1'b0, 1'b0);  // Drain, extra writes show up here
      if (trace_mem[base] == 16'd1) captured++;  // Start high before the frame
      check_value("fb_write count", got_words.size(), exp_count);
      for (int i = 0; i < exp_count; i++) begin
        check_value($sformatf("fb_word[%0d]", i), got_words[i], trace_mem[base + 35 + i]);
      end
      check_value("frame_count", frame_count, captured);
      got_words.delete();
    end
    if (dut_i.capture_i.chk_i.fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: bench/camera_trace.txt
// Frame header: start (0 low, 1 high, 2 raised after row 0), mode (1 RGB555, 0 hue), writes
// Then four rows of eight raw Bayer samples, then eight expected words (zeros if no writes)
0 1 0
123 456 789 ABC DEF 012 345 678
9AB CDE F01 234 567 89A BCD EF0
111 222 333 444 555 666 777 888
999 AAA BBB CCC DDD EEE FFF 000
0000 0000 0000 0000 0000 0000 0000 0000
1 1 8
FFF FF3 00F 00A 000 F80 100 007
FF0 FFF 005 00F 00C 01F 08F 301
340 12E 650 871 F00 0FA 5A0 A5D
569 341 43F 650 7F2 F1F C30 5AF
7FFF 0000 7C00 0081 08CA 4188 07CF 5178
2 0 0
0F0 F0F 0F0 F0F 0F0 F0F 0F0 F0F
5A5 A5A 5A5 A5A 5A5 A5A 5A5 A5A
321 654 987 CBA FED 210 543 876
135 246 357 468 579 68A 79B 8AC
0000 0000 0000 0000 0000 0000 0000 0000
1 0 8
800 80C 320 C8F 800 FF0 C80 0A1
803 800 640 320 00E 81F 3C2 C80
B40 645 1E0 5A0 640 00B 960 963
14A B40 DC7 1E0 FA0 64F 1E0 960
0000 00F2 0015 0060 0040 00B8 009A 002B

// File: hw/bayer_demosaic.sv
//====================================================================
// Bayer demosaic
// Buffers each even row and folds every 2x2 GR/BG block into one
// 8-bit RGB pixel, halving width and height
//====================================================================

module bayer_demosaic
  import video_pkg::*;
#(
  parameter int LINE_WIDTH = 1280  // Max raw columns per line
) (
  input  logic       ccd_pixel_clk,
  input  logic       rst,
  input  raw_pixel_t cap_data,
  input  logic       cap_valid,
  input  coord_t     cap_x,
  input  coord_t     cap_y,
  output color8_t    rgb_red,
  output color8_t    rgb_green,
  output color8_t    rgb_blue,
  output logic       rgb_valid
);

  localparam int ADDR_W = (LINE_WIDTH > 1) ? $clog2(LINE_WIDTH) : 1;

  // Pattern per 2x2 block
  //   even row  G R
  //   odd row   B G

  raw_pixel_t        line_buf [LINE_WIDTH];  // Previous even row
  logic [ADDR_W-1:0] col_addr;
  raw_pixel_t        above_now;   // Sample above the current column
  raw_pixel_t        prev_data;   // B sample, left of current G
  raw_pixel_t        prev_above;  // G sample from the row above
  logic              even_row;
  logic              odd_col;
  logic              block_done;  // Last sample of a 2x2 block
  logic [12:0]       green_sum;

  assign col_addr   = cap_x[ADDR_W-1:0];
  assign even_row   = ~cap_y[0];
  assign odd_col    = cap_x[0];
  assign above_now  = line_buf[col_addr];
  assign block_done = cap_valid & ~even_row & odd_col;

  // Both greens, one extra bit for the carry
  assign green_sum = {1'b0, prev_above} + {1'b0, cap_data};

  //====================================================================
  // Line buffer
  //====================================================================

  always_ff @(posedge ccd_pixel_clk) begin
    if (cap_valid && even_row) begin
      line_buf[col_addr] <= cap_data;
    end
  end

  // Left half of the block on the odd row
  always_ff @(posedge ccd_pixel_clk) begin
    if (cap_valid && !even_row && !odd_col) begin
      prev_data  <= cap_data;   // B
      prev_above <= above_now;  // G from even row
    end
  end

  //====================================================================
  // RGB output
  //====================================================================

  always_ff @(posedge ccd_pixel_clk) begin
    if (block_done) begin
      rgb_red   <= above_now[11:4];  // R sits above the current column
      rgb_blue  <= prev_data[11:4];
      rgb_green <= green_sum[12:5];  // Half the sum, top 8 bits
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      rgb_valid <= 1'b0;
    end else begin
      rgb_valid <= block_done;  // One pixel per block
    end
  end

endmodule

// File: hw/camera_pipeline_top.sv
//====================================================================
// Camera pipeline top
// Pixel-clock path from sensor pins to frame-buffer write words
// Capture, demosaic, hue and packing in a straight chain
//====================================================================

module camera_pipeline_top
  import video_pkg::*;
#(
  parameter int LINE_WIDTH = 1280  // Max raw columns per line
) (
  input  logic         ccd_pixel_clk,
  input  logic         rst,
  input  raw_pixel_t   pin_data,
  input  logic         pin_fval,
  input  logic         pin_lval,
  input  logic         start,        // Capture enable level
  input  pixel_mode_t  mode,         // Word format select
  output fb_word_t     fb_word,
  output logic         fb_write,
  output frame_count_t frame_count
);

  // Capture to demosaic
  raw_pixel_t cap_data;
  logic       cap_valid;
  coord_t     cap_x;
  coord_t     cap_y;

  // Demosaic to hue
  color8_t rgb_red;
  color8_t rgb_green;
  color8_t rgb_blue;
  logic    rgb_valid;

  // Hue to packer
  color8_t hue_red;
  color8_t hue_green;
  color8_t hue_blue;
  hue_t    hue_value;
  logic    hue_valid;

  ccd_capture #(
    .LINE_WIDTH (LINE_WIDTH)
  ) capture_i (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .pin_data      (pin_data),
    .pin_fval      (pin_fval),
    .pin_lval      (pin_lval),
    .start         (start),
    .cap_data      (cap_data),
    .cap_valid     (cap_valid),
    .cap_x         (cap_x),
    .cap_y         (cap_y),
    .frame_count   (frame_count)
  );

  bayer_demosaic #(
    .LINE_WIDTH (LINE_WIDTH)
  ) demosaic_i (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .cap_data      (cap_data),
    .cap_valid     (cap_valid),
    .cap_x         (cap_x),
    .cap_y         (cap_y),
    .rgb_red       (rgb_red),
    .rgb_green     (rgb_green),
    .rgb_blue      (rgb_blue),
    .rgb_valid     (rgb_valid)
  );

  rgb_hue_pipe hue_i (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .rgb_red       (rgb_red),
    .rgb_green     (rgb_green),
    .rgb_blue      (rgb_blue),
    .rgb_valid     (rgb_valid),
    .hue_red       (hue_red),
    .hue_green     (hue_green),
    .hue_blue      (hue_blue),
    .hue_value     (hue_value),
    .hue_valid     (hue_valid)
  );

  frame_word_packer packer_i (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .mode          (mode),
    .hue_red       (hue_red),
    .hue_green     (hue_green),
    .hue_blue      (hue_blue),
    .hue_value     (hue_value),
    .hue_valid     (hue_valid),
    .fb_word       (fb_word),
    .fb_write      (fb_write)
  );

endmodule

// File: hw/ccd_capture.sv
//====================================================================
// CCD capture stage
// Registers the sensor pins, admits whole frames only when start is
// high at the frame-valid rise, and tracks column, row and the number
// of captured frames
//====================================================================

module ccd_capture
  import video_pkg::*;
#(
  parameter int LINE_WIDTH = 1280  // Max raw columns per line
) (
  input  logic         ccd_pixel_clk,
  input  logic         rst,
  input  raw_pixel_t   pin_data,     // Raw sensor sample
  input  logic         pin_fval,     // Frame valid from sensor
  input  logic         pin_lval,     // Line valid from sensor
  input  logic         start,        // Capture enable level
  output raw_pixel_t   cap_data,
  output logic         cap_valid,
  output coord_t       cap_x,
  output coord_t       cap_y,
  output frame_count_t frame_count
);

  raw_pixel_t     data_q;     // Pin register
  logic           fval_q;
  logic           lval_q;
  logic           fval_prev;  // For edge detect
  logic           lval_prev;
  logic           fval_rise;
  logic           fval_fall;
  logic           lval_fall;
  coord_t         col_cnt;
  coord_t         row_cnt;
  capture_state_t state;
  capture_state_t state_next;

  assign fval_rise = fval_q & ~fval_prev;
  assign fval_fall = ~fval_q & fval_prev;
  assign lval_fall = ~lval_q & lval_prev;

  // Sample payload, no reset needed
  always_ff @(posedge ccd_pixel_clk) begin
    data_q   <= pin_data;
    cap_data <= data_q;
    cap_x    <= col_cnt;  // Index of the sample leaving with cap_data
    cap_y    <= row_cnt;
  end

  //====================================================================
  // Frame gating FSM
  //====================================================================

  always_comb begin
    state_next = state;
    case (state)
      CAP_IDLE: begin
        // Start exactly on a rise catches that frame
        if (start) state_next = fval_rise ? CAP_ACTIVE : CAP_ARMED;
      end
      CAP_ARMED: begin
        if (!start)         state_next = CAP_IDLE;
        else if (fval_rise) state_next = CAP_ACTIVE;
      end
      CAP_ACTIVE: begin
        if (fval_fall) state_next = start ? CAP_ARMED : CAP_IDLE;
      end
      default: state_next = CAP_IDLE;
    endcase
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      fval_q      <= 1'b0;
      lval_q      <= 1'b0;
      fval_prev   <= 1'b0;
      lval_prev   <= 1'b0;
      state       <= CAP_IDLE;
      col_cnt     <= '0;
      row_cnt     <= '0;
      cap_valid   <= 1'b0;
      frame_count <= '0;
    end else begin
      fval_q    <= pin_fval;
      lval_q    <= pin_lval;
      fval_prev <= fval_q;
      lval_prev <= lval_q;
      state     <= state_next;
      // Column restarts with every line
      col_cnt <= lval_q ? col_cnt + coord_t'(1) : '0;
      // Row restarts at frame start, steps at line end
      if (fval_rise)      row_cnt <= '0;
      else if (lval_fall) row_cnt <= row_cnt + coord_t'(1);
      cap_valid <= (state == CAP_ACTIVE) && fval_q && lval_q;
      if (state == CAP_ACTIVE && fval_fall) begin
        frame_count <= frame_count + frame_count_t'(1);  // Frame done
      end
    end
  end

endmodule

// File: hw/frame_word_packer.sv
//====================================================================
// Frame-buffer word packer
// Packs each pixel as RGB555 or hue into the 16-bit write word
//====================================================================

module frame_word_packer
  import video_pkg::*;
(
  input  logic        ccd_pixel_clk,
  input  logic        rst,
  input  pixel_mode_t mode,       // Sampled per pixel
  input  color8_t     hue_red,
  input  color8_t     hue_green,
  input  color8_t     hue_blue,
  input  hue_t        hue_value,
  input  logic        hue_valid,
  output fb_word_t    fb_word,
  output logic        fb_write    // Must be taken when high
);

  fb_word_t word_c;

  always_comb begin
    if (mode == MODE_RGB555) begin
      word_c = {1'b0, hue_red[7:3], hue_green[7:3], hue_blue[7:3]};
    end else begin
      word_c = {8'h00, hue_value};  // Hue in the low byte
    end
  end

  // Word only loads with a pixel
  always_ff @(posedge ccd_pixel_clk) begin
    if (hue_valid) begin
      fb_word <= word_c;
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      fb_write <= 1'b0;
    end else begin
      fb_write <= hue_valid;
    end
  end

endmodule

// File: hw/rgb_hue_pipe.sv
//====================================================================
// RGB to hue pipeline
// Three register stages compute hue on a 0..255 circle while the
// RGB components travel alongside at the same latency
//====================================================================

module rgb_hue_pipe
  import video_pkg::*;
(
  input  logic    ccd_pixel_clk,
  input  logic    rst,
  input  color8_t rgb_red,
  input  color8_t rgb_green,
  input  color8_t rgb_blue,
  input  logic    rgb_valid,
  output color8_t hue_red,
  output color8_t hue_green,
  output color8_t hue_blue,
  output hue_t    hue_value,
  output logic    hue_valid
);

  // Dominant channel codes
  localparam logic [1:0] DOM_R = 2'd0;
  localparam logic [1:0] DOM_G = 2'd1;
  localparam logic [1:0] DOM_B = 2'd2;

  color8_t            max_c;
  color8_t            min_c;
  logic [1:0]         dom_c;
  color8_t            s1_red;
  color8_t            s1_green;
  color8_t            s1_blue;
  color8_t            s1_max;
  color8_t            s1_min;
  logic [1:0]         s1_dom;
  logic               s1_valid;
  logic signed [8:0]  diff_c;    // Channel difference, -255..255
  hue_t               offset_c;  // Sector start
  color8_t            s2_red;
  color8_t            s2_green;
  color8_t            s2_blue;
  logic signed [15:0] s2_num;    // 43 * diff
  color8_t            s2_delta;
  hue_t               s2_offset;
  logic               s2_valid;
  logic signed [15:0] divisor_c;
  logic signed [15:0] quot_c;

  //====================================================================
  // Stage 1 finds max, min and dominant channel
  //====================================================================

  always_comb begin
    if (rgb_red >= rgb_green && rgb_red >= rgb_blue) begin
      dom_c = DOM_R;  // Ties go to R first
      max_c = rgb_red;
    end else if (rgb_green >= rgb_blue) begin
      dom_c = DOM_G;
      max_c = rgb_green;
    end else begin
      dom_c = DOM_B;
      max_c = rgb_blue;
    end
    min_c = rgb_red;
    if (rgb_green < min_c) min_c = rgb_green;
    if (rgb_blue < min_c)  min_c = rgb_blue;
  end

  always_ff @(posedge ccd_pixel_clk) begin
    s1_red   <= rgb_red;
    s1_green <= rgb_green;
    s1_blue  <= rgb_blue;
    s1_max   <= max_c;
    s1_min   <= min_c;
    s1_dom   <= dom_c;
  end

  //====================================================================
  // Stage 2 forms numerator, delta and sector offset
  //====================================================================

  always_comb begin
    case (s1_dom)
      DOM_G: begin
        diff_c   = $signed({1'b0, s1_blue}) - $signed({1'b0, s1_red});
        offset_c = 8'd85;
      end
      DOM_B: begin
        diff_c   = $signed({1'b0, s1_red}) - $signed({1'b0, s1_green});
        offset_c = 8'd171;
      end
      default: begin
        diff_c   = $signed({1'b0, s1_green}) - $signed({1'b0, s1_blue});
        offset_c = 8'd0;
      end
    endcase
  end

  always_ff @(posedge ccd_pixel_clk) begin
    s2_red    <= s1_red;
    s2_green  <= s1_green;
    s2_blue   <= s1_blue;
    s2_num    <= diff_c * 16'sd43;
    s2_delta  <= s1_max - s1_min;
    s2_offset <= offset_c;
  end

  //====================================================================
  // Stage 3 divides and wraps onto the circle
  //====================================================================

  // Signed divide truncates toward zero, grey pixels divide by one
  assign divisor_c = (s2_delta == '0) ? 16'sd1 : $signed({8'd0, s2_delta});
  assign quot_c    = s2_num / divisor_c;

  always_ff @(posedge ccd_pixel_clk) begin
    hue_red   <= s2_red;
    hue_green <= s2_green;
    hue_blue  <= s2_blue;
    // Grey sits in the R sector with a zero numerator, so it lands on 0
    hue_value <= s2_offset + hue_t'(quot_c[7:0]);  // 8-bit add wraps negative R by 256
  end

  // Valid chain
  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      hue_valid <= 1'b0;
    end else begin
      s1_valid  <= rgb_valid;
      s2_valid  <= s1_valid;
      hue_valid <= s2_valid;
    end
  end

endmodule

// File: hw/video_pkg.sv
//====================================================================
// Video path types
// Pixel, coordinate, word and counter widths shared by the
// pixel-clock camera pipeline, plus the FSM and mode encodings
//====================================================================

package video_pkg;

  //====================================================================
  // Data widths
  //====================================================================

  typedef logic [11:0] raw_pixel_t;    // One Bayer sample from the sensor
  typedef logic [7:0]  color8_t;       // Colour component after reduction
  typedef logic [7:0]  hue_t;          // Hue on a 0..255 circle
  typedef logic [11:0] coord_t;        // Column or row index
  typedef logic [31:0] frame_count_t;  // Captured frames since reset
  typedef logic [15:0] fb_word_t;      // Frame-buffer write word

  //====================================================================
  // Encodings
  //====================================================================

  // Capture FSM
  typedef enum logic [1:0] {
    CAP_IDLE   = 2'd0,  // Not capturing, start low
    CAP_ARMED  = 2'd1,  // Waiting for the next frame-valid rise
    CAP_ACTIVE = 2'd2   // Inside a captured frame
  } capture_state_t;

  // Frame-buffer word format
  typedef enum logic {
    MODE_HUE    = 1'b0,  // Eight zeros then hue
    MODE_RGB555 = 1'b1   // Zero bit then 5:5:5 colour
  } pixel_mode_t;

endpackage

// File: sim.f
hw/video_pkg.sv
hw/ccd_capture.sv
hw/bayer_demosaic.sv
hw/rgb_hue_pipe.sv
hw/frame_word_packer.sv
hw/camera_pipeline_top.sv
bench/camera_pipeline_chk.sv
bench/camera_pipeline_tb.sv
